/* design/lat_consts.svh */
`ifndef LAT_CONSTS_SVH
`define LAT_CONSTS_SVH

// request and memory widths
`define LAT_ADDR_W 8
`define LAT_DATA_W 32
`define LAT_TAG_W 4

// queue entries, equal to the credits the core holds after reset
`define LAT_QUEUE_DEPTH 4

// latency counter and lat_i width
`define LAT_CNT_W 32

`endif

/* design/lat_pkg.sv */
`include "lat_consts.svh"

package lat_pkg;

  // request from the core, 45 bits
  typedef struct packed {
    logic                      write;
    logic [`LAT_ADDR_W-1:0]    addr;
    logic [`LAT_DATA_W-1:0]    wdata;
    logic [`LAT_TAG_W-1:0]     tag;
  } cmd_t;

  // response to the core, 36 bits
  typedef struct packed {
    logic [`LAT_DATA_W-1:0]    rdata;
    logic [`LAT_TAG_W-1:0]     tag;
  } resp_t;

  // gate FSM
  // WAIT_DATA means latency expired with memory data still outstanding,
  // WAIT_TIME means data captured but latency not yet reached
  typedef enum logic [1:0] {
    READY     = 2'd0,
    BUSY      = 2'd1,
    WAIT_DATA = 2'd2,
    WAIT_TIME = 2'd3
  } gate_state_e;

endpackage

/* design/cmd_credit_if.sv */
`timescale 1ns/1ps

interface cmd_credit_if;

  logic            valid;   // head entry present
  lat_pkg::cmd_t   cmd;     // show-ahead head
  logic            credit;  // pop strobe from the gate
  logic            en;      // latency emulation on

  modport sender (
    output valid,
    output cmd,
    input  credit,
    input  en
  );

  modport receiver (
    input  valid,
    input  cmd,
    output credit,
    output en
  );

endinterface

/* design/cmd_credit_queue.sv */
`timescale 1ns/1ps
`include "lat_consts.svh"

module cmd_credit_queue (
  input  logic               ds_clk_i,
  input  logic               ds_reset_i,

  input  logic               req_v_i,
  input  lat_pkg::cmd_t      req_cmd_i,
  output logic               credit_o,

  cmd_credit_if.sender       deq
);

  localparam int DEPTH = `LAT_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  lat_pkg::cmd_t       mem_r [DEPTH];
  logic [PTR_W-1:0]    wr_ptr_r;
  logic [PTR_W-1:0]    rd_ptr_r;
  logic [CNT_W-1:0]    count_r;
  logic                credit_r;

  logic                push;
  logic                pop;

  // the core only sends while holding a credit, so a push never hits a full queue
  assign push = req_v_i;
  assign pop  = deq.credit & deq.valid;

  assign deq.valid = (count_r != '0);
  assign deq.cmd   = mem_r[rd_ptr_r]; // head shown ahead of the pop

  always_ff @(posedge ds_clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= req_cmd_i;
    end
  end

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      count_r <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;          // idle or push and pop together
      endcase
    end
  end

  // one credit back to the core per popped entry
  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      credit_r <= 1'b0;
    end else begin
      credit_r <= pop;
    end
  end

  assign credit_o = credit_r;

endmodule

/* design/latency_gate.sv */
`timescale 1ns/1ps
`include "lat_consts.svh"

module latency_gate (
  input  logic                   ds_clk_i,
  input  logic                   ds_reset_i,

  input  logic                   en_i,
  input  logic [`LAT_CNT_W-1:0]  lat_i,

  cmd_credit_if.receiver         enq,

  output logic                   mem_req_v_o,
  output lat_pkg::cmd_t          mem_cmd_o,
  input  logic                   mem_resp_v_i,
  input  lat_pkg::resp_t         mem_resp_i,

  output logic                   resp_v_o,
  output lat_pkg::resp_t         resp_o,
  output logic                   stall_o
);

  lat_pkg::gate_state_e      state_r;
  lat_pkg::gate_state_e      state_n;

  logic [`LAT_CNT_W-1:0]     cnt_r;
  logic                      run_r;     // counter running since issue
  lat_pkg::resp_t            resp_r;    // memory data held in WAIT_TIME

  logic                      issue;
  logic                      time_hit;
  logic                      time_done;

  assign enq.en = en_i;

  assign issue      = (state_r == lat_pkg::READY) & enq.valid;
  assign enq.credit = issue;            // pop the head as it goes out

  assign mem_req_v_o = issue;
  assign mem_cmd_o   = enq.cmd;

  // counter holds at lat_i once reached, so time_hit stays up until the next issue
  assign time_hit  = (cnt_r == lat_i);
  assign time_done = ~enq.en | time_hit; // pass-through has no time leg

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      cnt_r <= '0;
      run_r <= 1'b0;
    end else if (issue) begin
      cnt_r <= '0;
      run_r <= 1'b1;
    end else if (run_r) begin
      if (time_hit) begin
        run_r <= 1'b0;                  // expired
      end else if (cnt_r != '1) begin
        cnt_r <= cnt_r + 1'b1;          // saturate at all ones
      end
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      lat_pkg::READY: begin
        if (issue) begin
          state_n = lat_pkg::BUSY;
        end
      end
      lat_pkg::BUSY: begin
        if (mem_resp_v_i & time_done) begin
          state_n = lat_pkg::READY;
        end else if (mem_resp_v_i) begin
          state_n = lat_pkg::WAIT_TIME;
        end else if (time_done) begin
          state_n = lat_pkg::WAIT_DATA;
        end
      end
      lat_pkg::WAIT_TIME: begin
        if (time_done) begin
          state_n = lat_pkg::READY;
        end
      end
      lat_pkg::WAIT_DATA: begin
        if (mem_resp_v_i) begin
          state_n = lat_pkg::READY;
        end
      end
      default: state_n = lat_pkg::READY;
    endcase
  end

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      state_r <= lat_pkg::READY;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge ds_clk_i) begin
    if (mem_resp_v_i) begin
      resp_r <= mem_resp_i;
    end
  end

  // both legs done in this cycle
  assign resp_v_o = (state_r != lat_pkg::READY) & (state_n == lat_pkg::READY);
  assign resp_o   = (state_r == lat_pkg::WAIT_TIME) ? resp_r : mem_resp_i;

  assign stall_o = enq.en & (state_r == lat_pkg::WAIT_DATA);

endmodule

/* design/mem_responder.sv */
`timescale 1ns/1ps
`include "lat_consts.svh"

module mem_responder (
  input  logic             ds_clk_i,
  input  logic             ds_reset_i,

  input  logic             req_v_i,
  input  lat_pkg::cmd_t    req_cmd_i,

  output logic             resp_v_o,
  output lat_pkg::resp_t   resp_o
);

  localparam int WORDS = 2 ** `LAT_ADDR_W;

  logic [`LAT_DATA_W-1:0]  mem_r [WORDS];
  lat_pkg::cmd_t           cmd_r;       // access in flight
  logic [2:0]              cnt_r;       // cycles left, last one is 1
  logic                    busy_r;

  logic                    expire;

  assign expire = busy_r & (cnt_r == 3'd1);

  // one outstanding access, the gate never issues while busy
  always_ff @(posedge ds_clk_i) begin
    if (req_v_i) begin
      cmd_r <= req_cmd_i;
    end
  end

  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end else if (req_v_i) begin
      busy_r <= 1'b1;
      cnt_r  <= 3'd1 + {1'b0, req_cmd_i.addr[1:0]}; // delay set by the address
    end else if (expire) begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end else if (busy_r) begin
      cnt_r  <= cnt_r - 1'b1;
    end
  end

  // memory comes out of reset as all zeros
  always_ff @(posedge ds_clk_i) begin
    if (ds_reset_i) begin
      for (int i = 0; i < WORDS; i++) begin
        mem_r[i] <= '0;
      end
    end else if (expire & cmd_r.write) begin
      mem_r[cmd_r.addr] <= cmd_r.wdata;
    end
  end

  always_comb begin
    resp_o.tag   = cmd_r.tag;
    resp_o.rdata = cmd_r.write ? '0 : mem_r[cmd_r.addr]; // writes answer zero
  end

  assign resp_v_o = expire;

endmodule

/* design/lat_shim_top.sv */
`timescale 1ns/1ps
`include "lat_consts.svh"

module lat_shim_top (
  input  logic                    ds_clk_i,
  input  logic                    ds_reset_i,

  input  logic                    en_i,
  input  logic [`LAT_CNT_W-1:0]   lat_i,

  input  logic                    req_v_i,
  input  logic                    req_write_i,
  input  logic [`LAT_ADDR_W-1:0]  req_addr_i,
  input  logic [`LAT_DATA_W-1:0]  req_wdata_i,
  input  logic [`LAT_TAG_W-1:0]   req_tag_i,

  output logic                    credit_o,
  output logic                    resp_v_o,
  output logic [`LAT_DATA_W-1:0]  resp_rdata_o,
  output logic [`LAT_TAG_W-1:0]   resp_tag_o,
  output logic                    stall_o
);

  lat_pkg::cmd_t    req_cmd;
  lat_pkg::cmd_t    mem_cmd;
  lat_pkg::resp_t   mem_resp;
  lat_pkg::resp_t   resp;
  logic             mem_req_v;
  logic             mem_resp_v;

  cmd_credit_if cmd_if ();

  assign req_cmd.write = req_write_i;
  assign req_cmd.addr  = req_addr_i;
  assign req_cmd.wdata = req_wdata_i;
  assign req_cmd.tag   = req_tag_i;

  cmd_credit_queue u_queue (
    .ds_clk_i   (ds_clk_i),
    .ds_reset_i (ds_reset_i),
    .req_v_i    (req_v_i),
    .req_cmd_i  (req_cmd),
    .credit_o   (credit_o),
    .deq        (cmd_if.sender)
  );

  latency_gate u_gate (
    .ds_clk_i     (ds_clk_i),
    .ds_reset_i   (ds_reset_i),
    .en_i         (en_i),
    .lat_i        (lat_i),
    .enq          (cmd_if.receiver),
    .mem_req_v_o  (mem_req_v),
    .mem_cmd_o    (mem_cmd),
    .mem_resp_v_i (mem_resp_v),
    .mem_resp_i   (mem_resp),
    .resp_v_o     (resp_v_o),
    .resp_o       (resp),
    .stall_o      (stall_o)
  );

  mem_responder u_mem (
    .ds_clk_i   (ds_clk_i),
    .ds_reset_i (ds_reset_i),
    .req_v_i    (mem_req_v),
    .req_cmd_i  (mem_cmd),
    .resp_v_o   (mem_resp_v),
    .resp_o     (mem_resp)
  );

  assign resp_rdata_o = resp.rdata;
  assign resp_tag_o   = resp.tag;

endmodule

/* bench/tb_lat_shim.sv */
`timescale 1ns/1ps
`include "lat_consts.svh"

module tb_lat_shim;

  localparam int MAX_VEC = 64;
  localparam int DEPTH   = `LAT_QUEUE_DEPTH;

  logic                    ds_clk;
  logic                    ds_reset;
  logic                    en;
  logic [`LAT_CNT_W-1:0]   lat;
  logic                    req_v;
  logic                    req_write;
  logic [`LAT_ADDR_W-1:0]  req_addr;
  logic [`LAT_DATA_W-1:0]  req_wdata;
  logic [`LAT_TAG_W-1:0]   req_tag;
  logic                    credit;
  logic                    resp_v;
  logic [`LAT_DATA_W-1:0]  resp_rdata;
  logic [`LAT_TAG_W-1:0]   resp_tag;
  logic                    stall;

  logic                    v_en    [MAX_VEC];
  int                      v_lat   [MAX_VEC];
  logic                    v_write [MAX_VEC];
  logic [`LAT_ADDR_W-1:0]  v_addr  [MAX_VEC];
  logic [`LAT_DATA_W-1:0]  v_wdata [MAX_VEC];
  logic [`LAT_TAG_W-1:0]   v_tag   [MAX_VEC];
  logic [`LAT_DATA_W-1:0]  v_rdata [MAX_VEC];
  int                      nvec;
  int                      max_lat;

  lat_pkg::resp_t          exp_q [$];   // responses still owed, in request order
  int                      credits;
  int                      cycle;
  int                      limit;
  int                      received;
  int                      prev_resp;   // cycle of the last resp_v_o
  int                      stall_seen;
  logic                    have_prev;
  logic                    en_cur;
  int                      lat_cur;

  lat_shim_top dut0 (
    .ds_clk_i     (ds_clk),
    .ds_reset_i   (ds_reset),
    .en_i         (en),
    .lat_i        (lat),
    .req_v_i      (req_v),
    .req_write_i  (req_write),
    .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),
    .req_tag_i    (req_tag),
    .credit_o     (credit),
    .resp_v_o     (resp_v),
    .resp_rdata_o (resp_rdata),
    .resp_tag_o   (resp_tag),
    .stall_o      (stall)
  );

  always #2 ds_clk = ~ds_clk;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_resp(input string name, input lat_pkg::resp_t exp,
                            input lat_pkg::resp_t act);
    if (act !== exp) begin
      $display("Fail %s: expected tag %h rdata %h, actual tag %h rdata %h",
               name, exp.tag, exp.rdata, act.tag, act.rdata);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    int          f_en;
    int          f_lat;
    int          f_wr;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_tag;
    logic [31:0] f_rdata;
    nvec    = 0;
    max_lat = 0;
    fd = $fopen("bench/lat_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/lat_golden.txt");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or column notes
      n = $sscanf(line, "%d %d %d %h %h %h %h",
                  f_en, f_lat, f_wr, f_addr, f_wdata, f_tag, f_rdata);
      if (n != 7 || nvec == MAX_VEC) begin
        $display("golden file line %0d is malformed or past the vector limit", nvec);
        abort_run();
      end
      v_en[nvec]    = f_en[0];
      v_lat[nvec]   = f_lat;
      v_write[nvec] = f_wr[0];
      v_addr[nvec]  = f_addr[`LAT_ADDR_W-1:0];
      v_wdata[nvec] = f_wdata;
      v_tag[nvec]   = f_tag[`LAT_TAG_W-1:0];
      v_rdata[nvec] = f_rdata;
      if (f_lat > max_lat) max_lat = f_lat;
      nvec++;
    end
    $fclose(fd);
  endtask

  task automatic next_cycle();
    @(posedge ds_clk);
    #1;
  endtask

  task automatic send_request(input int i);
    lat_pkg::resp_t exp;
    if (credits <= 0) begin
      $display("request %0d would be sent without a credit", i);
      abort_run();
    end else begin
      exp.rdata = v_rdata[i];
      exp.tag   = v_tag[i];
      exp_q.push_back(exp);
      credits--;
      req_v     = 1'b1;
      req_write = v_write[i];
      req_addr  = v_addr[i];
      req_wdata = v_wdata[i];
      req_tag   = v_tag[i];
      next_cycle();
      req_v     = 1'b0;
    end
  endtask

  // wait until every response is back
  task automatic drain();
    while (exp_q.size() != 0) next_cycle();
  endtask

  task automatic watch_outputs();
    lat_pkg::resp_t exp;
    lat_pkg::resp_t got;
    if (credit) credits++;
    if (credits > DEPTH) begin
      $display("credit_o returned a credit that was never spent");
      abort_run();
    end else if (stall && (exp_q.size() == 0 || !en_cur)) begin
      $display("stall_o high with no response pending or with en low");
      abort_run();
    end else if (resp_v && exp_q.size() == 0) begin
      $display("resp_v_o pulsed with no request outstanding");
      abort_run();
    end else begin
      if (stall) stall_seen = 1;
      if (resp_v) begin
        exp       = exp_q.pop_front();
        got.rdata = resp_rdata;
        got.tag   = resp_tag;
        check_resp($sformatf("response %0d", received), exp, got);
        if (en_cur && have_prev && (cycle - prev_resp) < lat_cur + 1) begin
          check_count($sformatf("latency floor before response %0d", received),
                      lat_cur + 1, cycle - prev_resp);
        end
        have_prev = 1'b1;
        prev_resp = cycle;
        received++;
      end
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge ds_clk) begin
    if (!ds_reset) begin
      cycle++;
      if (cycle > limit) begin
        $display("timeout: run did not finish within %0d cycles", limit);
        abort_run();
      end else begin
        watch_outputs();
      end
    end
  end

  initial begin : drive
    int          i;
    int          sec;
    int          stall_expected;
    logic [31:0] rnd;
    ds_clk    = 1'b0;
    ds_reset  = 1'b1;
    en        = 1'b0;
    lat       = '0;
    req_v     = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_tag   = '0;
    credits   = DEPTH;
    cycle     = 0;
    received  = 0;
    prev_resp = 0;
    stall_seen = 0;
    have_prev = 1'b0;
    en_cur    = 1'b0;
    lat_cur   = 0;
    limit     = 1000;
    load_vectors();
    limit = nvec * (max_lat + 8) + 200;
    repeat (16) @(posedge ds_clk);
    #1;
    ds_reset = 1'b0;
    rnd = 32'hb437;
    sec = 0;
    stall_expected = 0;
    for (i = 0; i < nvec; i++) begin
      if (i == 0 || v_en[i] != en_cur || v_lat[i] != lat_cur) begin
        if (i != 0) begin
          drain();
          check_count($sformatf("stall seen in section %0d", sec), stall_expected, stall_seen);
          sec++;
        end
        en             = v_en[i];
        lat            = v_lat[i];
        en_cur         = v_en[i];
        lat_cur        = v_lat[i];
        have_prev      = 1'b0;
        stall_seen     = 0;
        stall_expected = 0;
      end
      rnd = next_rand(rnd);
      repeat (rnd % 4) next_cycle();
      while (credits == 0) next_cycle();
      // time leg ends lat+1 after issue, data leg 1+addr[1:0] after issue
      if (v_en[i] && v_lat[i] < int'(v_addr[i][1:0])) stall_expected = 1;
      send_request(i);
    end
    drain();
    check_count($sformatf("stall seen in section %0d", sec), stall_expected, stall_seen);
    check_count("credits after last response", DEPTH, credits);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* bench/lat_golden.txt */
# en lat write addr wdata tag exp_rdata
# en, lat, write in decimal; addr, wdata, tag, exp_rdata in hex
1 0 1 10 a5a50001 0 00000000
1 0 0 10 00000000 1 a5a50001
1 0 1 21 12345678 2 00000000
1 0 1 32 deadbeef 3 00000000
1 0 0 21 00000000 4 12345678
1 0 0 32 00000000 5 deadbeef
1 0 0 43 00000000 6 00000000
1 0 1 43 0badf00d 7 00000000
1 0 0 43 00000000 8 0badf00d

1 3 1 13 cafe0013 9 00000000
1 3 0 13 00000000 a cafe0013
1 3 0 10 00000000 b a5a50001
1 3 1 10 11110010 c 00000000
1 3 0 10 00000000 d 11110010
1 3 1 22 89abcdef e 00000000
1 3 0 22 00000000 f 89abcdef
1 3 0 55 00000000 0 00000000

0 7 1 55 55aa55aa 1 00000000
0 7 0 55 00000000 2 55aa55aa
0 7 0 21 00000000 3 12345678
0 7 1 21 00000021 4 00000000
0 7 0 21 00000000 5 00000021
0 7 1 ff ffff0000 6 00000000
0 7 0 ff 00000000 7 ffff0000
0 7 0 00 00000000 8 00000000

1 10 1 00 13579bdf 9 00000000
1 10 0 00 00000000 a 13579bdf
1 10 0 32 00000000 b deadbeef
1 10 1 32 00c0ffee c 00000000
1 10 0 32 00000000 d 00c0ffee
1 10 0 43 00000000 e 0badf00d
1 10 0 13 00000000 f cafe0013
1 10 0 ff 00000000 0 ffff0000

/* sources.f */
+incdir+design
design/lat_pkg.sv
design/cmd_credit_if.sv
design/cmd_credit_queue.sv
design/latency_gate.sv
design/mem_responder.sv
design/lat_shim_top.sv
bench/tb_lat_shim.sv

/* run_sim.sh */
#!/bin/sh
# compile the shim and its testbench with Verilator, then run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f sources.f \
  --top-module tb_lat_shim \
  -Mdir obj_dir

./obj_dir/Vtb_lat_shim
